// ==== Makefile ====
# Verilator build and run of the Cr quantizer testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_cr_quantizer
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST)) tb/quant_model.svh
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, so a failing run fails the target
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^TB PASSED$$' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/block_pkg.sv ====
/*
 * Geometry and coefficient types of one 8x8 DCT block.
 * Shared by every stage of the Cr quantizer and by the testbench.
 */

package block_pkg;

    // An 8x8 block holds 64 coefficients
    localparam int block_dim  = 8;
    localparam int block_size = block_dim * block_dim;

    // DCT coefficients and quantized results share one width
    localparam int coef_width = 11;

    // One two's complement coefficient
    typedef logic signed [coef_width-1:0] coef_t;

    // A whole block in row-major order, element row * block_dim + col
    typedef coef_t [block_size-1:0] coef_block_t;

endpackage

// ==== logic/cr_quantizer.sv ====
/*
 * Top level of the Cr block quantizer.
 * Takes a whole 8x8 block on a one-cycle enable and presents the quantized
 * block with out_enable four cycles later. A new block may start every cycle.
 */

`timescale 1ns/1ps

module cr_quantizer
    import block_pkg::*;
    import quant_table_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  coef_block_t coef_in,
    output coef_block_t coef_out,
    output logic        out_enable
);

    // Products and their strobe between the two halves
    prod_block_t prod;
    logic        prod_valid;

    // Capture and multiply take two cycles
    quant_scale u_quant_scale (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .coef_in    (coef_in),
        .prod       (prod),
        .prod_valid (prod_valid)
    );

    // Registering and rounding take two more cycles
    quant_round u_quant_round (
        .clk        (clk),
        .rst        (rst),
        .prod_valid (prod_valid),
        .prod       (prod),
        .coef_out   (coef_out),
        .out_enable (out_enable)
    );

endmodule

// ==== logic/quant_round.sv ====
/*
 * Back half of the Cr quantizer pipeline.
 * Registers the scaled products, then drops the fraction with round-half-up
 * to give 11-bit results. out_enable follows prod_valid by two cycles.
 */

`timescale 1ns/1ps

module quant_round
    import block_pkg::*;
    import quant_table_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        prod_valid,
    input  prod_block_t prod,
    output coef_block_t coef_out,
    output logic        out_enable
);

    logic  round_valid;
    prod_t prod_q [block_size];

    // Integer part of the product plus the half bit just below it
    // The sum wraps to the coefficient width
    function automatic coef_t round_half_up(input prod_t p);
        logic [coef_width-1:0] whole;
        logic [coef_width-1:0] half;
        whole = p[prod_width-1:recip_shift];
        half  = {{(coef_width - 1){1'b0}}, p[recip_shift-1]};
        return coef_t'(whole + half);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            round_valid <= 1'b0;
            out_enable  <= 1'b0;
        end else begin
            round_valid <= prod_valid;
            out_enable  <= round_valid;
        end
    end

    // Extra register stage between the multiply and the rounding
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            for (int i = 0; i < block_size; i++) begin
                prod_q[i] <= prod[i];
            end
        end
    end

    // Results change at the edge where out_enable rises and hold until
    // the next block arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            coef_out <= '0;
        end else if (round_valid) begin
            for (int i = 0; i < block_size; i++) begin
                coef_out[i] <= round_half_up(prod_q[i]);
            end
        end
    end

endmodule

// ==== logic/quant_scale.sv ====
/*
 * Front half of the Cr quantizer pipeline.
 * Captures a block on enable, then multiplies every coefficient by the
 * reciprocal of its chrominance step. prod_valid follows enable by two cycles.
 */

`timescale 1ns/1ps

module quant_scale
    import block_pkg::*;
    import quant_table_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  coef_block_t coef_in,
    output prod_block_t prod,
    output logic        prod_valid
);

    logic                  cap_valid;
    logic [prod_width-1:0] cap_q [block_size];

    // One strobe flop per pipeline stage
    always_ff @(posedge clk) begin
        if (rst) begin
            cap_valid  <= 1'b0;
            prod_valid <= 1'b0;
        end else begin
            cap_valid  <= enable;
            prod_valid <= cap_valid;
        end
    end

    // Coefficients are sign-extended to the product width on capture, so
    // the low bits of the multiply come out in two's complement
    always_ff @(posedge clk) begin
        if (enable) begin
            for (int i = 0; i < block_size; i++) begin
                cap_q[i] <= {{(prod_width - coef_width){coef_in[i][coef_width-1]}},
                             coef_in[i]};
            end
        end
    end

    // Multiply by the scaled reciprocal and keep the low prod_width bits
    // The reciprocal is positive, so it is zero-extended
    always_ff @(posedge clk) begin
        if (cap_valid) begin
            for (int r = 0; r < block_dim; r++) begin
                for (int c = 0; c < block_dim; c++) begin
                    prod[r*block_dim + c] <= cap_q[r*block_dim + c] *
                        {{(prod_width - recip_width){1'b0}}, chroma_recip[r*block_dim + c]};
                end
            end
        end
    end

endmodule

// ==== logic/quant_table_pkg.sv ====
/*
 * Quantization constants for the Cr channel.
 * Holds the standard JPEG chrominance steps, their reciprocals scaled by
 * 2**recip_shift, and the width of the products formed with them.
 */

package quant_table_pkg;

    import block_pkg::*;

    // Reciprocals are scaled by 4096, so the product is shifted right by 12
    localparam int recip_shift = 12;
    localparam int recip_width = 13;

    // Low bits of coefficient times reciprocal that the pipeline keeps
    localparam int prod_width = coef_width + recip_shift;

    typedef logic [prod_width-1:0] prod_t;
    typedef prod_t [block_size-1:0] prod_block_t;

    // Standard JPEG chrominance table in row-major order
    localparam int chroma_step [block_size] = '{
        17, 18, 24, 47, 99, 99, 99, 99,
        18, 21, 26, 66, 99, 99, 99, 99,
        24, 26, 56, 99, 99, 99, 99, 99,
        47, 66, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99
    };

    // Each entry is 4096 / chroma_step, truncated
    // The truncation adds a small loss on top of the quantization itself
    localparam logic [recip_width-1:0] chroma_recip [block_size] = '{
        13'd240, 13'd227, 13'd170, 13'd87, 13'd41, 13'd41, 13'd41, 13'd41,
        13'd227, 13'd195, 13'd157, 13'd62, 13'd41, 13'd41, 13'd41, 13'd41,
        13'd170, 13'd157, 13'd73,  13'd41, 13'd41, 13'd41, 13'd41, 13'd41,
        13'd87,  13'd62,  13'd41,  13'd41, 13'd41, 13'd41, 13'd41, 13'd41,
        13'd41,  13'd41,  13'd41,  13'd41, 13'd41, 13'd41, 13'd41, 13'd41,
        13'd41,  13'd41,  13'd41,  13'd41, 13'd41, 13'd41, 13'd41, 13'd41,
        13'd41,  13'd41,  13'd41,  13'd41, 13'd41, 13'd41, 13'd41, 13'd41,
        13'd41,  13'd41,  13'd41,  13'd41, 13'd41, 13'd41, 13'd41, 13'd41
    };

endpackage

// ==== tb.f ====
+incdir+tb
logic/block_pkg.sv
logic/quant_table_pkg.sv
logic/quant_scale.sv
logic/quant_round.sv
logic/cr_quantizer.sv
tb/tb_cr_quantizer.sv

// ==== tb/quant_model.svh ====
/*
 * Reference model of the Cr quantizer for the testbench.
 * Included inside the testbench module, which imports both packages.
 */

`ifndef QUANT_MODEL_SVH
`define QUANT_MODEL_SVH

// Product of a coefficient and its reciprocal, cut to the 23 bits the pipeline keeps
function automatic logic [22:0] model_product(input coef_t c, input int pos);
    int     recip;
    longint full;
    recip = (1 << recip_shift) / chroma_step[pos];
    full  = longint'(c) * longint'(recip);
    return full[22:0];
endfunction

// Integer part of the product plus the half bit, wrapped to 11 bits
function automatic coef_t expected_coef(input coef_t c, input int pos);
    logic [22:0] kept;
    logic [10:0] res;
    kept = model_product(c, pos);
    res  = kept[22:12] + {10'b0, kept[11]};
    return coef_t'(res);
endfunction

// Tells whether rounding adds one for this coefficient and position
function automatic logic half_bit_set(input coef_t c, input int pos);
    logic [22:0] kept;
    kept = model_product(c, pos);
    return kept[11];
endfunction

function automatic coef_block_t expected_block(input coef_block_t blk);
    coef_block_t res;
    for (int i = 0; i < block_size; i++) begin
        res[i] = expected_coef(blk[i], i);
    end
    return res;
endfunction

`endif

// ==== tb/tb_cr_quantizer.sv ====
/*
 * Testbench for the Cr block quantizer.
 * Sends directed and random blocks, predicts each result with the model in
 * quant_model.svh and checks latency, order, values and hold behavior.
 */

`timescale 1ns/1ps

module tb_cr_quantizer
    import block_pkg::*;
    import quant_table_pkg::*;
;

    localparam int reset_cycles    = 5;
    localparam int idle_cycles     = 3;
    localparam int directed_blocks = 2;
    localparam int random_blocks   = 10;
    localparam int drain_cycles    = 6;
    localparam int hold_cycles     = 8;
    localparam int stim_cycles     = reset_cycles + idle_cycles
                                   + directed_blocks + random_blocks
                                   + (directed_blocks + 1) * drain_cycles
                                   + hold_cycles + 2;
    localparam int timeout_cycles  = stim_cycles + 50;

    logic        clk;
    logic        rst;
    logic        enable;
    coef_block_t coef_in;
    coef_block_t coef_out;
    logic        out_enable;

    coef_block_t exp_q [$];
    coef_block_t head_blk;
    coef_block_t last_blk;
    logic [3:0]  en_hist;
    int          cycle_count;
    int          sent_count;
    int          pulse_count;
    int          value_errors;
    int          protocol_errors;
    int          coverage_errors;

    `include "quant_model.svh"

    cr_quantizer u_cr_quantizer (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .coef_in    (coef_in),
        .coef_out   (coef_out),
        .out_enable (out_enable)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        en_hist         = '0;
        cycle_count     = 0;
        sent_count      = 0;
        pulse_count     = 0;
        value_errors    = 0;
        protocol_errors = 0;
        coverage_errors = 0;
        last_blk        = '0;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("Errors: %0d value, %0d protocol, %0d coverage",
                     value_errors, protocol_errors, coverage_errors);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_block(input string name, input coef_block_t exp_blk,
                               input coef_block_t act_blk);
        for (int i = 0; i < block_size; i++) begin
            assert (act_blk[i] === exp_blk[i]) else begin
                $display("** Error: %s[%0d] expected %h got %h",
                         name, i, exp_blk[i], act_blk[i]);
                value_errors++;
            end
        end
    endtask

    // out_enable must follow enable by exactly four sampled edges
    always @(posedge clk) begin
        if (!rst) begin
            assert (out_enable === en_hist[3]) else begin
                if (out_enable === 1'b1) begin
                    $display("out_enable came without a block sent four cycles earlier");
                end else begin
                    $display("out_enable did not come four cycles after enable");
                end
                protocol_errors++;
            end
            if (out_enable === 1'b1) begin
                pulse_count++;
                if (exp_q.size() == 0) begin
                    $display("out_enable came while no block was expected");
                    protocol_errors++;
                end else begin
                    head_blk = exp_q.pop_front();
                    check_block("coef_out", head_blk, coef_out);
                    last_blk = head_blk;
                end
            end
        end
        en_hist = {en_hist[2:0], enable === 1'b1};
    end

    // Caller stands just after a rising edge; returns one edge later
    task automatic send_block(input coef_block_t blk);
        enable  <= 1'b1;
        coef_in <= blk;
        exp_q.push_back(expected_block(blk));
        sent_count++;
        @(posedge clk);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
    endtask

    function automatic coef_block_t random_block();
        coef_block_t blk;
        for (int i = 0; i < block_size; i++) begin
            blk[i] = coef_t'($urandom);
        end
        return blk;
    endfunction

    initial begin
        coef_block_t blk;
        int          half_set;
        int          half_clear;

        void'($urandom(92));
        rst     <= 1'b1;
        enable  <= 1'b0;
        coef_in <= '0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // Nothing may come out before the first block
        repeat (idle_cycles) begin
            @(posedge clk);
            assert (out_enable === 1'b0) else begin
                $display("** Error: out_enable expected %h got %h", 1'b0, out_enable);
                value_errors++;
            end
            check_block("coef_out", '0, coef_out);
        end

        // Extremes at step 17 and step 99, a few small values, zeros elsewhere
        blk     = '0;
        blk[0]  = -11'sd1024;
        blk[4]  = 11'sd1023;
        blk[9]  = 11'sd100;
        blk[18] = -11'sd77;
        blk[27] = 11'sd5;
        blk[40] = -11'sd3;
        blk[62] = 11'sd1023;
        blk[63] = -11'sd1024;
        send_block(blk);
        enable <= 1'b0;
        wait_drain();

        // Spread of values so the half bit is set at some positions only
        half_set   = 0;
        half_clear = 0;
        for (int i = 0; i < block_size; i++) begin
            blk[i] = coef_t'((i * 37) % 600 - 300);
        end
        blk[0] = 11'sd1023;
        for (int i = 0; i < block_size; i++) begin
            if (half_bit_set(blk[i], i)) begin
                half_set++;
            end else begin
                half_clear++;
            end
        end
        assert (half_set > 0 && half_clear > 0) else begin
            $display("Rounding block does not cover both half bit cases");
            coverage_errors++;
        end
        send_block(blk);
        enable <= 1'b0;
        wait_drain();

        // Random blocks on consecutive cycles
        for (int n = 0; n < random_blocks; n++) begin
            send_block(random_block());
        end
        enable <= 1'b0;
        wait_drain();

        // New inputs without enable must leave the output alone
        repeat (hold_cycles) begin
            coef_in <= random_block();
            @(posedge clk);
            assert (out_enable === 1'b0) else begin
                $display("** Error: out_enable expected %h got %h", 1'b0, out_enable);
                value_errors++;
            end
            check_block("coef_out", last_blk, coef_out);
        end

        @(posedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%0d blocks were sent but never came out", exp_q.size());
            protocol_errors++;
        end
        assert (pulse_count == sent_count) else begin
            $display("Saw %0d out_enable pulses for %0d blocks sent", pulse_count, sent_count);
            protocol_errors++;
        end

        $display("Errors: %0d value, %0d protocol, %0d coverage",
                 value_errors, protocol_errors, coverage_errors);
        if (value_errors == 0 && protocol_errors == 0 && coverage_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
